//--- exec_stage.f
exec_pkg.sv
operand_forward.sv
alu_unit.sv
mult_control.sv
mult_stage_counter.sv
mult_datapath.sv
completion_select.sv
exec_stage.sv
exec_stage_tb.sv

//--- Bender.yml
package:
  name: exec_stage

sources:
  - exec_pkg.sv
  - operand_forward.sv
  - alu_unit.sv
  - mult_control.sv
  - mult_stage_counter.sv
  - mult_datapath.sv
  - completion_select.sv
  - exec_stage.sv
  - target: test
    files:
      - exec_stage_tb.sv

//--- exec_stage_tb.sv
`timescale 1ns/100ps

module exec_stage_tb;

    logic                                             clock;
    logic                                             reset;
    logic                                             mispredict;
    logic                                             alu_valid;
    exec_pkg::alu_func_t                              alu_func;
    exec_pkg::opa_sel_t                               alu_opa_sel;
    exec_pkg::opb_sel_t                               alu_opb_sel;
    exec_pkg::data_t                                  alu_pc;
    exec_pkg::data_t                                  alu_imm;
    exec_pkg::tag_t                                   alu_src1_tag;
    exec_pkg::tag_t                                   alu_src2_tag;
    exec_pkg::tag_t                                   alu_dest_tag;
    exec_pkg::rob_idx_t                               alu_rob_idx;
    logic                                             mult_valid;
    exec_pkg::mult_func_t                             mult_func;
    exec_pkg::tag_t                                   mult_src1_tag;
    exec_pkg::tag_t                                   mult_src2_tag;
    exec_pkg::tag_t                                   mult_dest_tag;
    exec_pkg::rob_idx_t                               mult_rob_idx;
    logic                                             mult_ready;
    exec_pkg::tag_t                                   alu_rd_tag1;
    exec_pkg::tag_t                                   alu_rd_tag2;
    exec_pkg::tag_t                                   mult_rd_tag1;
    exec_pkg::tag_t                                   mult_rd_tag2;
    exec_pkg::data_t                                  alu_rd_data1;
    exec_pkg::data_t                                  alu_rd_data2;
    exec_pkg::data_t                                  mult_rd_data1;
    exec_pkg::data_t                                  mult_rd_data2;
    logic            [exec_pkg::CDB_LANES-1:0]        cdb_valid;
    exec_pkg::tag_t  [exec_pkg::CDB_LANES-1:0]        cdb_tag;
    exec_pkg::data_t [exec_pkg::CDB_LANES-1:0]        cdb_data;
    logic                                             alu_grant;
    logic                                             mult_grant;
    logic                                             mult_request;
    logic                                             ex_valid;
    logic                                             ex_cdb_valid;
    exec_pkg::data_t                                  ex_result;
    exec_pkg::tag_t                                   ex_dest_tag;
    exec_pkg::rob_idx_t                               ex_rob_idx;

    exec_pkg::data_t    prf [64];
    integer             seed;
    int                 errors;
    int                 test_start;
    int                 tests_run;
    int                 tests_failed;
    logic               checking;
    logic               exp_valid;
    exec_pkg::data_t    exp_result;
    exec_pkg::tag_t     exp_dest;
    exec_pkg::rob_idx_t exp_rob;
    exec_pkg::data_t    mult_exp_result;
    exec_pkg::tag_t     mult_exp_dest;
    exec_pkg::rob_idx_t mult_exp_rob;

    exec_stage dut0 (.*);

    always #50 clock = ~clock;

    // PRF model answers the read tags in the same cycle
    assign alu_rd_data1  = prf[alu_rd_tag1];
    assign alu_rd_data2  = prf[alu_rd_tag2];
    assign mult_rd_data1 = prf[mult_rd_tag1];
    assign mult_rd_data2 = prf[mult_rd_tag2];

    // ========================================================================
    // Reference model
    // ========================================================================
    // Highest valid lane with a matching tag wins over the PRF
    function automatic exec_pkg::data_t resolve_operand(input exec_pkg::tag_t tag);
        for (int lane = exec_pkg::CDB_LANES - 1; lane >= 0; lane--) begin
            if (cdb_valid[lane] && (cdb_tag[lane] == tag)) begin
                return cdb_data[lane];
            end
        end
        return prf[tag];
    endfunction

    function automatic exec_pkg::data_t exec_expect(input bit is_mult, input int func,
        input int opa_sel, input int opb_sel, input exec_pkg::data_t pc,
        input exec_pkg::data_t imm, input exec_pkg::data_t rs1, input exec_pkg::data_t rs2);
        exec_pkg::data_t a;
        exec_pkg::data_t b;
        logic [63:0]     ae;
        logic [63:0]     be;
        logic [63:0]     p;
        if (is_mult) begin
            // Extended product modulo 2^64 keeps the high word exact
            ae = {{32{rs1[31] && (func != exec_pkg::MUL_HI_UU)}}, rs1};
            be = {{32{rs2[31] && (func <= exec_pkg::MUL_HI_SS)}}, rs2};
            p  = ae * be;
            return (func == exec_pkg::MUL_LO) ? p[31:0] : p[63:32];
        end
        case (opa_sel)
            exec_pkg::OPA_RS1: a = rs1;
            exec_pkg::OPA_NPC: a = pc + exec_pkg::INSN_BYTES;
            exec_pkg::OPA_PC:  a = pc;
            default:           a = 32'h0;
        endcase
        b = (opb_sel == exec_pkg::OPB_IMM) ? imm : rs2;
        case (func)
            exec_pkg::ALU_ADD:  return a + b;
            exec_pkg::ALU_SUB:  return a - b;
            exec_pkg::ALU_AND:  return a & b;
            exec_pkg::ALU_OR:   return a | b;
            exec_pkg::ALU_XOR:  return a ^ b;
            exec_pkg::ALU_SLL:  return a << b[4:0];
            exec_pkg::ALU_SRL:  return a >> b[4:0];
            exec_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
            exec_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exec_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:            return 32'h0;
        endcase
    endfunction

    function automatic int random_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic exec_pkg::tag_t any_tag();
        return exec_pkg::tag_t'($random(seed));
    endfunction

    // ========================================================================
    // Checking
    // ========================================================================
    task automatic check_value(input string name, input logic [31:0] got,
        input logic [31:0] want);
        if (got !== want) begin
            $display("ERR %s: got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    // Completion port compare
    always @(negedge clock) begin
        if (checking) begin
            check_value("ex_valid", ex_valid, exp_valid);
            if (exp_valid) begin
                check_value("ex_result", ex_result, exp_result);
                check_value("ex_dest_tag", ex_dest_tag, exp_dest);
                check_value("ex_rob_idx", ex_rob_idx, exp_rob);
                check_value("ex_cdb_valid", ex_cdb_valid, exp_dest != 0);
            end
        end
    end

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_start) begin
            tests_failed++;
        end
        $display("%s finished with %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    task automatic abort_run(input string what);
        $display("Timed out waiting for %s", what);
        $display("TEST FAILED");
        $finish;
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================
    task automatic set_cdb(input logic [1:0] valid, input exec_pkg::tag_t t0,
        input exec_pkg::tag_t t1, input exec_pkg::data_t d0, input exec_pkg::data_t d1);
        @(posedge clock);
        cdb_valid <= valid;
        cdb_tag   <= {t1, t0};
        cdb_data  <= {d1, d0};
    endtask

    // One ALU op, granted in its issue cycle
    task automatic alu_op(input int func, input int opa, input int opb,
        input exec_pkg::tag_t s1, input exec_pkg::tag_t s2, input exec_pkg::tag_t dest);
        exec_pkg::data_t    pc;
        exec_pkg::data_t    imm;
        exec_pkg::rob_idx_t rob;
        pc  = $random(seed);
        imm = $random(seed);
        rob = exec_pkg::rob_idx_t'($random(seed));
        @(posedge clock);
        alu_valid    <= 1'b1;
        alu_grant    <= 1'b1;
        alu_func     <= exec_pkg::alu_func_t'(func);
        alu_opa_sel  <= exec_pkg::opa_sel_t'(opa);
        alu_opb_sel  <= exec_pkg::opb_sel_t'(opb);
        alu_pc       <= pc;
        alu_imm      <= imm;
        alu_src1_tag <= s1;
        alu_src2_tag <= s2;
        alu_dest_tag <= dest;
        alu_rob_idx  <= rob;
        exp_valid    <= 1'b1;
        exp_result   <= exec_expect(0, func, opa, opb, pc, imm, resolve_operand(s1),
                                    resolve_operand(s2));
        exp_dest     <= dest;
        exp_rob      <= rob;
        @(negedge clock);
        check_value("alu_rd_tag1", alu_rd_tag1, s1);
        check_value("alu_rd_tag2", alu_rd_tag2, s2);
        @(posedge clock);
        alu_valid <= 1'b0;
        alu_grant <= 1'b0;
        exp_valid <= 1'b0;
    endtask

    // Returns once the accept edge has passed
    task automatic mult_issue(input int func, input exec_pkg::tag_t s1,
        input exec_pkg::tag_t s2);
        int t;
        @(posedge clock);
        mult_valid      <= 1'b1;
        mult_func       <= exec_pkg::mult_func_t'(func);
        mult_src1_tag   <= s1;
        mult_src2_tag   <= s2;
        mult_exp_dest   = any_tag();
        mult_exp_rob    = exec_pkg::rob_idx_t'($random(seed));
        mult_dest_tag   <= mult_exp_dest;
        mult_rob_idx    <= mult_exp_rob;
        mult_exp_result = exec_expect(1, func, 0, 0, 0, 0, resolve_operand(s1),
                                      resolve_operand(s2));
        t = 0;
        @(negedge clock);
        check_value("mult_rd_tag1", mult_rd_tag1, s1);
        check_value("mult_rd_tag2", mult_rd_tag2, s2);
        while (!mult_ready) begin
            t++;
            if (t > 20) abort_run("mult_ready");
            @(negedge clock);
        end
        @(posedge clock);
        mult_valid <= 1'b0;
    endtask

    task automatic wait_for_request;
        int cycles;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            if (cycles > 20) abort_run("mult_request");
            @(negedge clock);
            check_value("mult_ready", mult_ready, 1'b0);
        end while (!mult_request);
        check_value("mult_request latency", cycles, exec_pkg::MULT_LATENCY);
    endtask

    task automatic grant_mult;
        @(posedge clock);
        mult_grant <= 1'b1;
        exp_valid  <= 1'b1;
        exp_result <= mult_exp_result;
        exp_dest   <= mult_exp_dest;
        exp_rob    <= mult_exp_rob;
        @(negedge clock);
        check_value("mult_ready", mult_ready, 1'b0);
        @(posedge clock);
        mult_grant <= 1'b0;
        exp_valid  <= 1'b0;
        @(negedge clock);
        check_value("mult_ready", mult_ready, 1'b1);
        check_value("mult_request", mult_request, 1'b0);
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        exec_pkg::tag_t s1;
        exec_pkg::tag_t s2;
        int             n;
        seed          = 86808;
        errors        = 0;
        test_start    = 0;
        tests_run     = 0;
        tests_failed  = 0;
        checking      = 1'b0;
        exp_valid     = 1'b0;
        exp_result    = '0;
        exp_dest      = '0;
        exp_rob       = '0;
        clock         = 1'b0;
        reset         = 1'b0;
        mispredict    = 1'b0;
        alu_valid     = 1'b0;
        alu_func      = exec_pkg::ALU_ADD;
        alu_opa_sel   = exec_pkg::OPA_RS1;
        alu_opb_sel   = exec_pkg::OPB_RS2;
        alu_pc        = '0;
        alu_imm       = '0;
        alu_src1_tag  = '0;
        alu_src2_tag  = '0;
        alu_dest_tag  = '0;
        alu_rob_idx   = '0;
        mult_valid    = 1'b0;
        mult_func     = exec_pkg::MUL_LO;
        mult_src1_tag = '0;
        mult_src2_tag = '0;
        mult_dest_tag = '0;
        mult_rob_idx  = '0;
        cdb_valid     = '0;
        cdb_tag       = '0;
        cdb_data      = '0;
        alu_grant     = 1'b0;
        mult_grant    = 1'b0;
        // P0 always reads as zero
        prf[0] = '0;
        for (int r = 1; r < 64; r++) begin
            prf[r] = $random(seed);
        end

        repeat (2) @(posedge clock);
        reset    <= 1'b1;
        checking <= 1'b1;
        @(negedge clock);
        check_value("mult_ready", mult_ready, 1'b1);
        check_value("mult_request", mult_request, 1'b0);
        check_value("ex_valid", ex_valid, 1'b0);
        end_test("reset");

        // Every operand select, first op of each group writes P0
        for (int opa = 0; opa < 4; opa++) begin
            for (int opb = 0; opb < 2; opb++) begin
                for (int i = 0; i < 6; i++) begin
                    alu_op(random_below(10), opa, opb, any_tag(), any_tag(),
                           (i == 0) ? exec_pkg::tag_t'(0) : any_tag());
                end
            end
        end
        end_test("alu");

        // Lane 1 carries s2, or a second copy of s1 in the upper half
        for (int i = 0; i < 8; i++) begin
            s1 = any_tag();
            s2 = any_tag();
            set_cdb(2'(i), s1, (i >= 4) ? s1 : s2, $random(seed), $random(seed));
            alu_op(exec_pkg::ALU_ADD, exec_pkg::OPA_RS1, exec_pkg::OPB_RS2, s1, s2, any_tag());
            mult_issue(exec_pkg::MUL_LO, s1, s2);
            wait_for_request;
            grant_mult;
        end
        set_cdb(2'b00, '0, '0, '0, '0);
        end_test("forwarding");

        for (int i = 0; i < 12; i++) begin
            mult_issue(i % 4, any_tag(), any_tag());
            wait_for_request;
            grant_mult;
        end
        end_test("multiply");

        for (int i = 0; i < 4; i++) begin
            mult_issue(random_below(4), any_tag(), any_tag());
            wait_for_request;
            n = random_below(6) + 1;
            repeat (n) begin
                alu_op(random_below(10), random_below(4), random_below(2), any_tag(),
                       any_tag(), any_tag());
                // Issue side moves on while the product waits
                mult_func     <= exec_pkg::mult_func_t'(random_below(4));
                mult_src1_tag <= any_tag();
                mult_src2_tag <= any_tag();
                mult_dest_tag <= any_tag();
                @(negedge clock);
                check_value("mult_request", mult_request, 1'b1);
                check_value("mult_ready", mult_ready, 1'b0);
            end
            grant_mult;
        end
        end_test("back-pressure");

        // Flush lands one, two and three cycles into BUSY
        for (int i = 0; i < 3; i++) begin
            mult_issue(random_below(4), any_tag(), any_tag());
            repeat (i + 1) @(posedge clock);
            mispredict <= 1'b1;
            @(posedge clock);
            mispredict <= 1'b0;
            @(negedge clock);
            check_value("mult_ready", mult_ready, 1'b1);
            check_value("mult_request", mult_request, 1'b0);
            repeat (6) begin
                @(negedge clock);
                check_value("mult_request", mult_request, 1'b0);
            end
            mult_issue(random_below(4), any_tag(), any_tag());
            wait_for_request;
            grant_mult;
        end
        end_test("flush");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- exec_stage.sv
`timescale 1ns/100ps

module exec_stage (
    input  logic                                      clock,
    input  logic                                      reset,
    input  logic                                      mispredict,

    // ALU issue
    input  logic                                      alu_valid,
    input  exec_pkg::alu_func_t                       alu_func,
    input  exec_pkg::opa_sel_t                        alu_opa_sel,
    input  exec_pkg::opb_sel_t                        alu_opb_sel,
    input  exec_pkg::data_t                           alu_pc,
    input  exec_pkg::data_t                           alu_imm,
    input  exec_pkg::tag_t                            alu_src1_tag,
    input  exec_pkg::tag_t                            alu_src2_tag,
    input  exec_pkg::tag_t                            alu_dest_tag,
    input  exec_pkg::rob_idx_t                        alu_rob_idx,

    // Multiply issue
    input  logic                                      mult_valid,
    input  exec_pkg::mult_func_t                      mult_func,
    input  exec_pkg::tag_t                            mult_src1_tag,
    input  exec_pkg::tag_t                            mult_src2_tag,
    input  exec_pkg::tag_t                            mult_dest_tag,
    input  exec_pkg::rob_idx_t                        mult_rob_idx,
    output logic                                      mult_ready,

    // PRF reads
    output exec_pkg::tag_t                            alu_rd_tag1,
    output exec_pkg::tag_t                            alu_rd_tag2,
    output exec_pkg::tag_t                            mult_rd_tag1,
    output exec_pkg::tag_t                            mult_rd_tag2,
    input  exec_pkg::data_t                           alu_rd_data1,
    input  exec_pkg::data_t                           alu_rd_data2,
    input  exec_pkg::data_t                           mult_rd_data1,
    input  exec_pkg::data_t                           mult_rd_data2,

    // CDB snoop
    input  logic            [exec_pkg::CDB_LANES-1:0] cdb_valid,
    input  exec_pkg::tag_t  [exec_pkg::CDB_LANES-1:0] cdb_tag,
    input  exec_pkg::data_t [exec_pkg::CDB_LANES-1:0] cdb_data,

    // Request/grant
    input  logic                                      alu_grant,
    input  logic                                      mult_grant,
    output logic                                      mult_request,

    // Completion port
    output logic                                      ex_valid,
    output logic                                      ex_cdb_valid,
    output exec_pkg::data_t                           ex_result,
    output exec_pkg::tag_t                            ex_dest_tag,
    output exec_pkg::rob_idx_t                        ex_rob_idx
);

    exec_pkg::data_t    alu_rs1;
    exec_pkg::data_t    alu_rs2;
    exec_pkg::data_t    mult_rs1;
    exec_pkg::data_t    mult_rs2;
    exec_pkg::data_t    alu_result;
    exec_pkg::data_t    mult_result;
    exec_pkg::tag_t     mult_dest_tag_q;
    exec_pkg::rob_idx_t mult_rob_idx_q;
    logic               mult_start;
    logic               mult_count_done;

    // ========================================================================
    // Operand resolution
    // ========================================================================
    assign alu_rd_tag1  = alu_src1_tag;
    assign alu_rd_tag2  = alu_src2_tag;
    assign mult_rd_tag1 = mult_src1_tag;
    assign mult_rd_tag2 = mult_src2_tag;

    operand_forward fwd_alu1 (.rd_tag(alu_rd_tag1), .rd_data(alu_rd_data1),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data), .value(alu_rs1));
    operand_forward fwd_alu2 (.rd_tag(alu_rd_tag2), .rd_data(alu_rd_data2),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data), .value(alu_rs2));
    operand_forward fwd_mult1 (.rd_tag(mult_rd_tag1), .rd_data(mult_rd_data1),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data), .value(mult_rs1));
    operand_forward fwd_mult2 (.rd_tag(mult_rd_tag2), .rd_data(mult_rd_data2),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data), .value(mult_rs2));

    // ========================================================================
    // Units
    // ========================================================================
    alu_unit alu0 (.func(alu_func), .opa_sel(alu_opa_sel), .opb_sel(alu_opb_sel),
        .pc(alu_pc), .imm(alu_imm), .rs1(alu_rs1), .rs2(alu_rs2), .result(alu_result));

    // Multiply, flushed on mispredict
    mult_control mult_ctrl0 (.clock(clock), .reset(reset), .flush(mispredict),
        .issue_valid(mult_valid), .grant(mult_grant), .count_done(mult_count_done),
        .ready(mult_ready), .request(mult_request), .start(mult_start));

    mult_stage_counter mult_cnt0 (.clock(clock), .reset(reset), .flush(mispredict),
        .start(mult_start), .done(mult_count_done));

    mult_datapath mult_dp0 (.clock(clock), .reset(reset), .start(mult_start),
        .func(mult_func), .rs1(mult_rs1), .rs2(mult_rs2), .dest_tag(mult_dest_tag),
        .rob_idx(mult_rob_idx), .result(mult_result), .dest_tag_out(mult_dest_tag_q),
        .rob_idx_out(mult_rob_idx_q));

    // ========================================================================
    // Completion
    // ========================================================================
    completion_select comp0 (
        .alu_valid(alu_valid),
        .alu_grant(alu_grant),
        .alu_result(alu_result),
        .alu_dest_tag(alu_dest_tag),
        .alu_rob_idx(alu_rob_idx),
        .mult_request(mult_request),
        .mult_grant(mult_grant),
        .mult_result(mult_result),
        .mult_dest_tag(mult_dest_tag_q),
        .mult_rob_idx(mult_rob_idx_q),
        .ex_valid(ex_valid),
        .ex_cdb_valid(ex_cdb_valid),
        .ex_result(ex_result),
        .ex_dest_tag(ex_dest_tag),
        .ex_rob_idx(ex_rob_idx)
    );

endmodule

//--- completion_select.sv
`timescale 1ns/100ps

module completion_select (
    // ALU side
    input  logic               alu_valid,
    input  logic               alu_grant,
    input  exec_pkg::data_t    alu_result,
    input  exec_pkg::tag_t     alu_dest_tag,
    input  exec_pkg::rob_idx_t alu_rob_idx,

    // Multiply side
    input  logic               mult_request,
    input  logic               mult_grant,
    input  exec_pkg::data_t    mult_result,
    input  exec_pkg::tag_t     mult_dest_tag,
    input  exec_pkg::rob_idx_t mult_rob_idx,

    // Completion port
    output logic               ex_valid,
    output logic               ex_cdb_valid,
    output exec_pkg::data_t    ex_result,
    output exec_pkg::tag_t     ex_dest_tag,
    output exec_pkg::rob_idx_t ex_rob_idx
);

    logic alu_fire;
    logic mult_fire;

    // A grant only counts against a live candidate
    assign alu_fire  = alu_valid && alu_grant;
    assign mult_fire = mult_request && mult_grant;

    always_comb begin
        ex_result   = '0;
        ex_dest_tag = '0;
        ex_rob_idx  = '0;
        if (mult_fire) begin
            ex_result   = mult_result;
            ex_dest_tag = mult_dest_tag;
            ex_rob_idx  = mult_rob_idx;
        end else if (alu_fire) begin
            ex_result   = alu_result;
            ex_dest_tag = alu_dest_tag;
            ex_rob_idx  = alu_rob_idx;
        end
    end

    assign ex_valid     = alu_fire || mult_fire;
    // P0 writes never go out on the CDB
    assign ex_cdb_valid = ex_valid && (ex_dest_tag != '0);

endmodule

//--- mult_datapath.sv
`timescale 1ns/100ps

module mult_datapath (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 start,
    input  exec_pkg::mult_func_t func,
    input  exec_pkg::data_t      rs1,
    input  exec_pkg::data_t      rs2,
    input  exec_pkg::tag_t       dest_tag,
    input  exec_pkg::rob_idx_t   rob_idx,
    output exec_pkg::data_t      result,
    output exec_pkg::tag_t       dest_tag_out,
    output exec_pkg::rob_idx_t   rob_idx_out
);

    localparam int MSB = exec_pkg::DATA_WIDTH - 1;

    exec_pkg::mult_func_t func_q;
    exec_pkg::data_t      rs1_q;
    exec_pkg::data_t      rs2_q;
    exec_pkg::data_t      product_word;
    logic                 start_d;

    logic signed [exec_pkg::DATA_WIDTH:0]       opa_ext;
    logic signed [exec_pkg::DATA_WIDTH:0]       opb_ext;
    logic signed [2*exec_pkg::DATA_WIDTH+1:0]   product;

    // ========================================================================
    // Capture at accept
    // ========================================================================
    always_ff @(posedge clock) begin
        if (start) begin
            func_q       <= func;
            rs1_q        <= rs1;
            rs2_q        <= rs2;
            dest_tag_out <= dest_tag;
            rob_idx_out  <= rob_idx;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            start_d <= 1'b0;
        end else begin
            start_d <= start;
        end
    end

    // Sign extension per function, MUL_LO is the same either way
    always_comb begin
        opa_ext      = {(func_q != exec_pkg::MUL_HI_UU) & rs1_q[MSB], rs1_q};
        opb_ext      = {((func_q == exec_pkg::MUL_LO) || (func_q == exec_pkg::MUL_HI_SS))
                        & rs2_q[MSB], rs2_q};
        product      = opa_ext * opb_ext;
        product_word = (func_q == exec_pkg::MUL_LO) ? product[MSB:0]
                                                    : product[2*MSB+1:MSB+1];
    end

    // Product register, held until the next multiply
    always_ff @(posedge clock) begin
        if (start_d) begin
            result <= product_word;
        end
    end

endmodule

//--- mult_stage_counter.sv
`timescale 1ns/100ps

module mult_stage_counter (
    input  logic clock,
    input  logic reset,
    input  logic flush,
    input  logic start,
    output logic done
);

    exec_pkg::mult_count_t count;
    logic                  active;

    // Loaded at the accept edge, reaches zero three edges later,
    // so the FSM leaves BUSY on the fourth edge after accept
    always_ff @(posedge clock) begin
        if (!reset) begin
            active <= 1'b0;
            count  <= '0;
        end else if (flush) begin
            active <= 1'b0;
            count  <= '0;
        end else if (start) begin
            active <= 1'b1;
            count  <= exec_pkg::mult_count_t'(exec_pkg::MULT_LATENCY - 1);
        end else if (done) begin
            active <= 1'b0;
        end else if (active) begin
            count <= count - 1'b1;
        end
    end

    assign done = active && (count == '0);

endmodule

//--- mult_control.sv
`timescale 1ns/100ps

module mult_control (
    input  logic clock,
    input  logic reset,
    input  logic flush,
    input  logic issue_valid,
    input  logic grant,
    input  logic count_done,
    output logic ready,
    output logic request,
    output logic start
);

    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        BUSY       = 2'd1,
        WAIT_GRANT = 2'd2
    } state_t;

    state_t state;
    state_t state_next;

    // ========================================================================
    // State register
    // ========================================================================
    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= IDLE;
        end else if (flush) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:       if (start)      state_next = BUSY;
            BUSY:       if (count_done) state_next = WAIT_GRANT;
            WAIT_GRANT: if (grant)      state_next = IDLE;
            default:                    state_next = IDLE;
        endcase
    end

    // Handshake outputs
    assign ready   = (state == IDLE);
    assign request = (state == WAIT_GRANT);

    // A multiply issued alongside a flush is on the wrong path, drop it
    assign start = ready && issue_valid && !flush;

endmodule

//--- alu_unit.sv
`timescale 1ns/100ps

module alu_unit (
    input  exec_pkg::alu_func_t func,
    input  exec_pkg::opa_sel_t  opa_sel,
    input  exec_pkg::opb_sel_t  opb_sel,
    input  exec_pkg::data_t     pc,
    input  exec_pkg::data_t     imm,
    input  exec_pkg::data_t     rs1,
    input  exec_pkg::data_t     rs2,
    output exec_pkg::data_t     result
);

    exec_pkg::data_t opa;
    exec_pkg::data_t opb;
    logic [4:0]      shamt;

    // ========================================================================
    // Operand selection
    // ========================================================================
    always_comb begin
        case (opa_sel)
            exec_pkg::OPA_RS1:  opa = rs1;
            exec_pkg::OPA_NPC:  opa = pc + exec_pkg::data_t'(exec_pkg::INSN_BYTES);
            exec_pkg::OPA_PC:   opa = pc;
            exec_pkg::OPA_ZERO: opa = '0;
            default:            opa = '0;
        endcase
    end

    assign opb = (opb_sel == exec_pkg::OPB_IMM) ? imm : rs2;

    // RV32I shifts only look at the low five bits
    assign shamt = opb[4:0];

    // ========================================================================
    // Operations
    // ========================================================================
    always_comb begin
        case (func)
            exec_pkg::ALU_ADD:  result = opa + opb;
            exec_pkg::ALU_SUB:  result = opa - opb;
            exec_pkg::ALU_AND:  result = opa & opb;
            exec_pkg::ALU_OR:   result = opa | opb;
            exec_pkg::ALU_XOR:  result = opa ^ opb;
            exec_pkg::ALU_SLL:  result = opa << shamt;
            exec_pkg::ALU_SRL:  result = opa >> shamt;
            exec_pkg::ALU_SRA:  result = $signed(opa) >>> shamt;
            exec_pkg::ALU_SLT: begin
                result = {{(exec_pkg::DATA_WIDTH-1){1'b0}}, $signed(opa) < $signed(opb)};
            end
            exec_pkg::ALU_SLTU: begin
                result = {{(exec_pkg::DATA_WIDTH-1){1'b0}}, opa < opb};
            end
            // Unused codes
            default:            result = '0;
        endcase
    end

endmodule

//--- operand_forward.sv
`timescale 1ns/100ps

module operand_forward (
    input  exec_pkg::tag_t                                rd_tag,
    input  exec_pkg::data_t                               rd_data,
    input  logic            [exec_pkg::CDB_LANES-1:0]     cdb_valid,
    input  exec_pkg::tag_t  [exec_pkg::CDB_LANES-1:0]     cdb_tag,
    input  exec_pkg::data_t [exec_pkg::CDB_LANES-1:0]     cdb_data,
    output exec_pkg::data_t                               value
);

    logic [exec_pkg::CDB_LANES-1:0] lane_hit;

    // Per-lane tag compare
    always_comb begin
        for (int lane = 0; lane < exec_pkg::CDB_LANES; lane++) begin
            lane_hit[lane] = cdb_valid[lane] && (cdb_tag[lane] == rd_tag);
        end
    end

    // Default to the register file read
    // later lanes override earlier ones, so the highest hit wins
    always_comb begin
        value = rd_data;
        for (int lane = 0; lane < exec_pkg::CDB_LANES; lane++) begin
            if (lane_hit[lane]) begin
                value = cdb_data[lane];
            end
        end
    end

endmodule

//--- exec_pkg.sv
package exec_pkg;

    // ========================================================================
    // Widths
    // ========================================================================
    localparam int DATA_WIDTH = 32;
    localparam int TAG_WIDTH  = 6;
    localparam int ROB_WIDTH  = 5;

    typedef logic [DATA_WIDTH-1:0] data_t;
    // 64 physical registers, P0 reads as zero
    typedef logic [TAG_WIDTH-1:0]  tag_t;
    typedef logic [ROB_WIDTH-1:0]  rob_idx_t;

    // ========================================================================
    // Stage sizing
    // ========================================================================
    localparam int CDB_LANES    = 2;
    localparam int MULT_LATENCY = 4;
    localparam int INSN_BYTES   = 4;

    typedef logic [$clog2(MULT_LATENCY + 1)-1:0] mult_count_t;

    // ========================================================================
    // Function and select codes
    // ========================================================================
    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_OR   = 4'h3,
        ALU_XOR  = 4'h4,
        ALU_SLL  = 4'h5,
        ALU_SRL  = 4'h6,
        ALU_SRA  = 4'h7,
        ALU_SLT  = 4'h8,
        ALU_SLTU = 4'h9
    } alu_func_t;

    // MUL, MULH, MULHSU, MULHU
    typedef enum logic [1:0] {
        MUL_LO    = 2'd0,
        MUL_HI_SS = 2'd1,
        MUL_HI_SU = 2'd2,
        MUL_HI_UU = 2'd3
    } mult_func_t;

    typedef enum logic [1:0] {
        OPA_RS1  = 2'd0,
        OPA_NPC  = 2'd1,
        OPA_PC   = 2'd2,
        OPA_ZERO = 2'd3
    } opa_sel_t;

    typedef enum logic {
        OPB_RS2 = 1'b0,
        OPB_IMM = 1'b1
    } opb_sel_t;

endpackage
